// ==== hdl/synth_pkg.sv ====
`default_nettype none

package synth_pkg;

    // --------------------------------------------------
    // sizes and rates
    // --------------------------------------------------
    localparam int num_voices = 4;
    localparam int note_w     = 7;
    localparam int vel_w      = 7;
    localparam int phase_w    = 24;
    localparam int sample_w   = 8;
    localparam int sample_div = 3125;  // 32 kHz sample rate from a 100 MHz clock
    localparam int octave_top = 10;    // the step table holds this octave
    localparam int semitones  = 12;

    localparam string step_file = "hdl/step_table.hex";

    // --------------------------------------------------
    // shared types
    // --------------------------------------------------
    typedef logic [1:0] voice_t;

    typedef enum logic [1:0] {
        wave_saw    = 2'd0,
        wave_square = 2'd1,
        wave_tri    = 2'd2
    } wave_t;

    typedef struct packed {
        voice_t             voice;
        logic [note_w-1:0]  note;
        logic [vel_w-1:0]   vel;
    } voice_req_t;

    typedef struct packed {
        voice_t             voice;
        logic [vel_w-1:0]   vel;
        logic [phase_w-1:0] step;
    } voice_step_t;

    typedef struct packed {
        voice_t             voice;
        logic [vel_w-1:0]   vel;
        logic [phase_w-1:0] phase;
    } voice_phase_t;

    typedef struct packed {
        voice_t                     voice;
        logic signed [sample_w-1:0] level;  // waveform already scaled by velocity
    } voice_level_t;

endpackage

`default_nettype wire

// ==== hdl/sample_tick.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_tick (
    input  wire logic CLK,
    input  wire logic reset,
    input  wire logic seq_idle,
    input  wire logic out_empty,
    output logic      frame_start,
    output logic      overrun
);
    import synth_pkg::*;

    localparam int cnt_w = $clog2(sample_div);

    logic [cnt_w-1:0] div_cnt;
    logic             tick;
    logic             can_start;

    assign tick      = (div_cnt == cnt_w'(sample_div - 1));
    assign can_start = seq_idle && out_empty;  // previous frame fully drained and accepted

    // a frame starts in the tick cycle itself, so the sequencer latches inputs on that edge
    assign frame_start = tick && can_start;

    always_ff @(posedge CLK) begin
        if (reset) begin
            div_cnt <= '0;
            overrun <= 1'b0;
        end else begin
            if (tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (tick && !can_start) begin
                overrun <= 1'b1;  // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/voice_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module voice_sequencer (
    input  wire logic CLK,
    input  wire logic reset,
    input  wire logic frame_start,
    input  wire logic [synth_pkg::num_voices-1:0][synth_pkg::note_w-1:0] note_num,
    input  wire logic [synth_pkg::num_voices-1:0][synth_pkg::vel_w-1:0]  note_vel,
    output logic                  seq_idle,
    output synth_pkg::voice_req_t req,
    output logic                  req_valid,
    input  wire logic             req_ready
);
    import synth_pkg::*;

    typedef enum logic {
        st_idle,
        st_run
    } seq_state_t;

    seq_state_t state;
    voice_t     voice_cnt;
    logic       last_voice;

    logic [num_voices-1:0][note_w-1:0] note_q;
    logic [num_voices-1:0][vel_w-1:0]  vel_q;

    assign last_voice = (voice_cnt == voice_t'(num_voices - 1));

    // --------------------------------------------------
    // frame control
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            state     <= st_idle;
            voice_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (frame_start) begin
                        state     <= st_run;
                        voice_cnt <= '0;
                    end
                end
                st_run: begin
                    if (req_valid && req_ready) begin
                        voice_cnt <= voice_cnt + 1'b1;
                        if (last_voice) begin
                            state <= st_idle;  // all four voices handed off
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // snapshot of every voice so that a mid-frame input change cannot tear a sample
    always_ff @(posedge CLK) begin
        if (frame_start) begin
            note_q <= note_num;
            vel_q  <= note_vel;
        end
    end

    assign seq_idle  = (state == st_idle);
    assign req_valid = (state == st_run);

    assign req.voice = voice_cnt;
    assign req.note  = note_q[voice_cnt];
    assign req.vel   = vel_q[voice_cnt];

endmodule

`default_nettype wire

// ==== hdl/step_lookup.sv ====
`timescale 1ns/10ps
`default_nettype none

module step_lookup (
    input  wire logic                   CLK,
    input  wire logic                   reset,
    input  wire synth_pkg::voice_req_t  req,
    input  wire logic                   req_valid,
    output logic                        req_ready,
    output synth_pkg::voice_step_t      stp,
    output logic                        stp_valid,
    input  wire logic                   stp_ready
);
    import synth_pkg::*;

    logic [phase_w-1:0] step_rom [semitones];

    logic [note_w-1:0] octave_raw;
    logic [3:0]        octave;
    logic [3:0]        semitone;
    logic [3:0]        shift;

    initial begin
        $readmemh(step_file, step_rom);  // top octave steps, one per semitone
    end

    assign octave_raw = req.note / note_w'(semitones);
    assign semitone   = 4'(req.note % note_w'(semitones));
    assign octave     = (octave_raw > note_w'(octave_top)) ? 4'(octave_top) : octave_raw[3:0];
    assign shift      = 4'(octave_top) - octave;  // each octave down halves the step

    assign req_ready = !stp_valid || stp_ready;

    always_ff @(posedge CLK) begin
        if (reset) begin
            stp_valid <= 1'b0;
        end else if (req_ready) begin
            stp_valid <= req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid && req_ready) begin
            stp.voice <= req.voice;
            stp.vel   <= req.vel;
            stp.step  <= step_rom[semitone] >> shift;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/phase_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module phase_bank (
    input  wire logic                   CLK,
    input  wire logic                   reset,
    input  wire synth_pkg::voice_step_t stp,
    input  wire logic                   stp_valid,
    output logic                        stp_ready,
    output synth_pkg::voice_phase_t     ph,
    output logic                        ph_valid,
    input  wire logic                   ph_ready
);
    import synth_pkg::*;

    logic [phase_w-1:0] phase_q [num_voices];
    logic [phase_w-1:0] phase_next;
    logic               accept;

    assign accept     = stp_valid && stp_ready;
    assign phase_next = phase_q[stp.voice] + stp.step;  // wraps at 2**phase_w

    assign stp_ready = !ph_valid || ph_ready;

    // --------------------------------------------------
    // per-voice accumulators
    // --------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            phase_q  <= '{default: '0};
            ph_valid <= 1'b0;
        end else begin
            if (stp_ready) begin
                ph_valid <= stp_valid;
            end
            if (accept) begin
                phase_q[stp.voice] <= phase_next;
            end
        end
    end

    // the new phase goes downstream, so the first frame already sees one step
    always_ff @(posedge CLK) begin
        if (accept) begin
            ph.voice <= stp.voice;
            ph.vel   <= stp.vel;
            ph.phase <= phase_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wave_shaper.sv ====
`timescale 1ns/10ps
`default_nettype none

module wave_shaper (
    input  wire logic                    CLK,
    input  wire logic                    reset,
    input  wire synth_pkg::wave_t        wave,
    input  wire synth_pkg::voice_phase_t ph,
    input  wire logic                    ph_valid,
    output logic                         ph_ready,
    output synth_pkg::voice_level_t      lvl,
    output logic                         lvl_valid,
    input  wire logic                    lvl_ready
);
    import synth_pkg::*;

    logic [7:0]                 p;
    logic signed [9:0]          tri_wide;
    logic signed [sample_w-1:0] tri_sat;
    logic signed [sample_w-1:0] raw;
    logic signed [15:0]         prod;
    logic signed [15:0]         prod_sh;

    assign p = ph.phase[phase_w-1:phase_w-8];

    // --------------------------------------------------
    // waveform generation
    // --------------------------------------------------
    always_comb begin
        if (!p[7]) begin
            tri_wide = $signed({1'b0, p, 1'b0}) - 10'sd128;  // rising half
        end else begin
            tri_wide = 10'sd383 - $signed({1'b0, p, 1'b0});  // falling half
        end

        if (tri_wide > 10'sd127) begin
            tri_sat = 8'sd127;
        end else if (tri_wide < -10'sd128) begin
            tri_sat = -8'sd128;
        end else begin
            tri_sat = tri_wide[7:0];
        end

        case (wave)
            wave_saw:    raw = $signed(p);
            wave_square: raw = p[7] ? -8'sd127 : 8'sd127;
            wave_tri:    raw = tri_sat;
            default:     raw = '0;
        endcase
    end

    assign prod    = raw * $signed({1'b0, ph.vel});  // velocity 127 is just under unity gain
    assign prod_sh = prod >>> 7;

    assign ph_ready = !lvl_valid || lvl_ready;

    always_ff @(posedge CLK) begin
        if (reset) begin
            lvl_valid <= 1'b0;
        end else if (ph_ready) begin
            lvl_valid <= ph_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (ph_valid && ph_ready) begin
            lvl.voice <= ph.voice;
            lvl.level <= prod_sh[sample_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/voice_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

module voice_mixer (
    input  wire logic                    CLK,
    input  wire logic                    reset,
    input  wire synth_pkg::voice_level_t lvl,
    input  wire logic                    lvl_valid,
    output logic                         lvl_ready,
    output logic                         out_empty,
    output logic signed [synth_pkg::sample_w-1:0] sample,
    output logic                         sample_valid,
    input  wire logic                    sample_ready
);
    import synth_pkg::*;

    logic signed [9:0] acc;
    logic signed [9:0] sum_next;
    logic              last_level;
    logic              accept;

    assign accept     = lvl_valid && lvl_ready;
    assign last_level = (lvl.voice == voice_t'(num_voices - 1));
    assign sum_next   = acc + {{(10 - sample_w){lvl.level[sample_w-1]}}, lvl.level};

    // a finished sample blocks new levels until it leaves
    assign lvl_ready = !sample_valid || sample_ready;
    assign out_empty = !sample_valid;

    always_ff @(posedge CLK) begin
        if (reset) begin
            acc          <= '0;
            sample_valid <= 1'b0;
        end else begin
            if (sample_valid && sample_ready) begin
                sample_valid <= 1'b0;
            end
            if (accept) begin
                if (last_level) begin
                    acc          <= '0;  // ready for the next frame
                    sample_valid <= 1'b1;
                end else begin
                    acc <= sum_next;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept && last_level) begin
            sample <= sample_w'(sum_next >>> 2);  // average of four voices
        end
    end

endmodule

`default_nettype wire

// ==== hdl/nco_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module nco_bank (
    input  wire logic CLK,
    input  wire logic reset,
    input  wire logic [synth_pkg::num_voices-1:0][synth_pkg::note_w-1:0] note_num,
    input  wire logic [synth_pkg::num_voices-1:0][synth_pkg::vel_w-1:0]  note_vel,
    input  wire synth_pkg::wave_t                  wave,
    output logic signed [synth_pkg::sample_w-1:0]  sample,
    output logic                                   sample_valid,
    input  wire logic                              sample_ready,
    output logic                                   overrun
);
    import synth_pkg::*;

    logic frame_start;
    logic seq_idle;
    logic out_empty;

    // --------------------------------------------------
    // pipeline links
    // --------------------------------------------------
    voice_req_t   req;
    logic         req_valid;
    logic         req_ready;
    voice_step_t  stp;
    logic         stp_valid;
    logic         stp_ready;
    voice_phase_t ph;
    logic         ph_valid;
    logic         ph_ready;
    voice_level_t lvl;
    logic         lvl_valid;
    logic         lvl_ready;

    sample_tick tick0 (
        .CLK(CLK), .reset(reset), .seq_idle(seq_idle), .out_empty(out_empty),
        .frame_start(frame_start), .overrun(overrun)
    );

    voice_sequencer seq0 (
        .CLK(CLK), .reset(reset), .frame_start(frame_start),
        .note_num(note_num), .note_vel(note_vel), .seq_idle(seq_idle),
        .req(req), .req_valid(req_valid), .req_ready(req_ready)
    );

    step_lookup step0 (
        .CLK(CLK), .reset(reset), .req(req), .req_valid(req_valid), .req_ready(req_ready),
        .stp(stp), .stp_valid(stp_valid), .stp_ready(stp_ready)
    );

    phase_bank phase0 (
        .CLK(CLK), .reset(reset), .stp(stp), .stp_valid(stp_valid), .stp_ready(stp_ready),
        .ph(ph), .ph_valid(ph_valid), .ph_ready(ph_ready)
    );

    wave_shaper shaper0 (
        .CLK(CLK), .reset(reset), .wave(wave),
        .ph(ph), .ph_valid(ph_valid), .ph_ready(ph_ready),
        .lvl(lvl), .lvl_valid(lvl_valid), .lvl_ready(lvl_ready)
    );

    voice_mixer mixer0 (
        .CLK(CLK), .reset(reset), .lvl(lvl), .lvl_valid(lvl_valid), .lvl_ready(lvl_ready),
        .out_empty(out_empty), .sample(sample), .sample_valid(sample_valid),
        .sample_ready(sample_ready)
    );

endmodule

`default_nettype wire

// ==== verification/tb_nco_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_nco_bank;
    import synth_pkg::*;

    localparam int num_rows    = 10;
    localparam int reset_len   = 10;
    localparam int half_period = 20;

    typedef struct packed {
        logic [num_voices-1:0][note_w-1:0] notes;  // voice 3 is the leftmost entry
        logic [num_voices-1:0][vel_w-1:0]  vels;
        wave_t                             wave;
        logic [7:0]                        n_samples;
        logic [15:0]                       stall;
        logic                              ovr;
    } row_t;

    // --------------------------------------------------
    // stimulus table
    // --------------------------------------------------
    localparam row_t rows [num_rows] = '{
        '{{7'd72, 7'd67, 7'd64, 7'd60}, {7'd0, 7'd0, 7'd0, 7'd0}, wave_saw, 8'd3, 16'd0, 1'b0},
        '{{7'd72, 7'd67, 7'd64, 7'd60}, {7'd0, 7'd0, 7'd0, 7'd0}, wave_square, 8'd2, 16'd0, 1'b0},
        '{{7'd72, 7'd67, 7'd64, 7'd60}, {7'd0, 7'd0, 7'd0, 7'd0}, wave_tri, 8'd2, 16'd0, 1'b0},
        '{{7'd72, 7'd67, 7'd64, 7'd60}, {7'd64, 7'd80, 7'd100, 7'd127}, wave_saw, 8'd4, 16'd2,
          1'b0},
        '{{7'd127, 7'd119, 7'd45, 7'd0}, {7'd127, 7'd127, 7'd127, 7'd127}, wave_saw, 8'd4, 16'd0,
          1'b0},
        '{{7'd88, 7'd81, 7'd76, 7'd69}, {7'd30, 7'd60, 7'd90, 7'd127}, wave_square, 8'd4, 16'd1,
          1'b0},
        '{{7'd123, 7'd122, 7'd121, 7'd120}, {7'd127, 7'd127, 7'd127, 7'd127}, wave_tri, 8'd5,
          16'd0, 1'b0},
        '{{7'd91, 7'd103, 7'd115, 7'd127}, {7'd127, 7'd127, 7'd127, 7'd127}, wave_tri, 8'd4,
          16'd3, 1'b0},
        '{{7'd74, 7'd69, 7'd66, 7'd62}, {7'd110, 7'd110, 7'd110, 7'd110}, wave_saw, 8'd2,
          16'd3200, 1'b1},
        '{{7'd65, 7'd62, 7'd57, 7'd50}, {7'd127, 7'd127, 7'd127, 7'd127}, wave_square, 8'd3,
          16'd0, 1'b1}
    };

    logic                              CLK;
    logic                              reset;
    logic [num_voices-1:0][note_w-1:0] note_num;
    logic [num_voices-1:0][vel_w-1:0]  note_vel;
    wave_t                             wave;
    logic signed [sample_w-1:0]        sample;
    logic                              sample_valid;
    logic                              sample_ready;
    logic                              overrun;

    logic [phase_w-1:0] model_steps [semitones];
    logic [phase_w-1:0] model_phase [num_voices];
    integer             seed;

    nco_bank dut0 (
        .CLK(CLK), .reset(reset), .note_num(note_num), .note_vel(note_vel), .wave(wave),
        .sample(sample), .sample_valid(sample_valid), .sample_ready(sample_ready),
        .overrun(overrun)
    );

    initial begin
        CLK = 1'b0;
        forever #half_period CLK = ~CLK;
    end

    // --------------------------------------------------
    // reference model and compare tasks
    // --------------------------------------------------
    task automatic advance_model(input row_t r, output logic signed [sample_w-1:0] expected);
        int                 v;
        int                 octave;
        int                 p;
        int                 raw;
        int                 sum;
        logic [phase_w-1:0] step;
        sum = 0;
        for (v = 0; v < num_voices; v++) begin
            octave = int'(r.notes[v]) / semitones;
            if (octave > octave_top) begin
                octave = octave_top;  // top notes reuse the highest octave
            end
            step = model_steps[int'(r.notes[v]) % semitones] >> (octave_top - octave);
            model_phase[v] = model_phase[v] + step;
            p = int'(model_phase[v][phase_w-1 -: 8]);
            case (r.wave)
                wave_saw:    raw = (p >= 128) ? p - 256 : p;
                wave_square: raw = (p >= 128) ? -127 : 127;
                wave_tri: begin
                    raw = (p < 128) ? 2 * p - 128 : 383 - 2 * p;
                    if (raw > 127) raw = 127;
                    if (raw < -128) raw = -128;
                end
                default:     raw = 0;
            endcase
            sum = sum + ((raw * int'(r.vels[v])) >>> 7);
        end
        expected = sample_w'(sum >>> 2);
    endtask

    task automatic check_sample(input logic signed [sample_w-1:0] got,
                                input logic signed [sample_w-1:0] expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "flag mismatch");
        end
    endtask

    // returns on the edge where the sample is taken
    task automatic collect_sample(input int stall, input logic signed [sample_w-1:0] expected,
                                  input string what);
        int i;
        @(negedge CLK);
        while (sample_valid !== 1'b1) @(negedge CLK);
        check_sample(sample, expected, what);
        for (i = 0; i < stall; i++) begin
            @(negedge CLK);
            check_flag(sample_valid, 1'b1, {what, " valid while stalled"});
            check_sample(sample, expected, {what, " while stalled"});
        end
        @(posedge CLK);
        sample_ready <= 1'b1;
        @(negedge CLK);
        check_flag(sample_valid, 1'b1, {what, " valid before transfer"});
        @(posedge CLK);
        sample_ready <= 1'b0;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int                         r;
        int                         s;
        int                         stall;
        logic signed [sample_w-1:0] expected;
        reset        = 1'b1;
        note_num     = '0;
        note_vel     = '0;
        wave         = wave_saw;
        sample_ready = 1'b0;
        seed         = 20;
        $readmemh(step_file, model_steps);
        for (s = 0; s < num_voices; s++) begin
            model_phase[s] = '0;
        end

        repeat (reset_len) @(posedge CLK);
        reset <= 1'b0;

        for (r = 0; r < num_rows; r++) begin
            // new inputs land on the transfer edge, before the next frame can start
            note_num <= rows[r].notes;
            note_vel <= rows[r].vels;
            wave     <= rows[r].wave;
            stall = int'(rows[r].stall);
            if (r > 0) begin
                stall = stall + int'($unsigned($random(seed)) % 16);
            end
            if (r > 0) begin
                @(negedge CLK);
                check_flag(overrun, rows[r-1].ovr, $sformatf("overrun after row %0d", r - 1));
            end
            for (s = 0; s < int'(rows[r].n_samples); s++) begin
                advance_model(rows[r], expected);
                collect_sample(stall, expected, $sformatf("row %0d sample %0d", r, s));
            end
        end
        @(negedge CLK);
        check_flag(overrun, rows[num_rows-1].ovr, "overrun after last row");

        $display("=== PASS ===");
        $finish;
    end

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    initial begin
        int limit;
        int r;
        limit = reset_len;
        for (r = 0; r < num_rows; r++) begin
            limit = limit + (int'(rows[r].n_samples) + 1) * sample_div * 2;
            limit = limit + int'(rows[r].n_samples) * (int'(rows[r].stall) + 16);
        end
        repeat (limit) @(posedge CLK);
        $display("timeout: no sample arrived within %0d clock cycles", limit);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== hdl/step_table.hex ====
// phase step per semitone for octave 10, from semitone 0 (C) up to semitone 11 (B)
42F9DB
46F567
4B2D92
4FA5F9
54626D
596704
5EB7E8
6459C1
6A5159
70A3C7
77566E
7E6F17

// ==== nco_bank.f ====
hdl/synth_pkg.sv
hdl/sample_tick.sv
hdl/voice_sequencer.sv
hdl/step_lookup.sv
hdl/phase_bank.sv
hdl/wave_shaper.sv
hdl/voice_mixer.sv
hdl/nco_bank.sv
verification/tb_nco_bank.sv

// ==== Makefile ====
# Verilator build and run for the oscillator bank testbench

VERILATOR ?= verilator
TOP       ?= tb_nco_bank
FILELIST  ?= nco_bank.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, so the simulator's own exit status is ignored here
run: compile
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
